/* src/redmule_pkg.sv */
/*
 * RedMulE package: array sizes, element types, PE opcodes and the
 * command struct shared by the feeder, the PE row and the drain
 */

package redmule_pkg;

  // Array geometry and element widths
  localparam int unsigned NUM_PE = 4;
  localparam int unsigned OPND_W = 8;
  localparam int unsigned ACC_W  = 24;
  localparam int unsigned K_W    = 6;

  // Signed operand and accumulator elements
  typedef logic signed [OPND_W-1:0] opnd_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // One weight per PE, element j belongs to PE j
  typedef opnd_t [NUM_PE-1:0] w_row_t;

  // Bias and result vectors share the accumulator width
  typedef acc_t [NUM_PE-1:0] acc_vec_t;

  // PE opcode
  typedef enum logic [1:0] {
    OP_IDLE = 2'd0,
    OP_BIAS = 2'd1,
    OP_MAC  = 2'd2
  } pe_op_e;

  // Command broadcast from the feeder to every PE
  typedef struct packed {
    pe_op_e op;
    logic   last;   // final beat of the job
    opnd_t  x;
    w_row_t w;
  } pe_cmd_t;

  // Feeder FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BIAS = 2'd1,
    ST_RUN  = 2'd2
  } pe_state_e;

endpackage : redmule_pkg

/* src/redmule_feeder.sv */
/*
 * RedMulE feeder: job scheduler FSM that registers the start and the beats
 * and issues one registered command per event to the PE row
 */

`timescale 1ns/1ps

module redmule_feeder (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  logic [redmule_pkg::K_W-1:0] k_len_i,
  input  redmule_pkg::acc_vec_t       y_bias_i,
  input  logic                        beat_valid_i,
  input  redmule_pkg::opnd_t          x_i,
  input  redmule_pkg::w_row_t         w_i,
  input  logic                        z_valid_i,
  output logic                        busy_o,
  output redmule_pkg::pe_cmd_t        cmd_o,
  output redmule_pkg::acc_vec_t       bias_o
);

  import redmule_pkg::*;

  pe_state_e      state_q, state_d;
  logic [K_W-1:0] remain_q;
  logic           busy_q;
  logic           start_acc;
  logic           beat_acc;
  logic           beat_last;
  logic           beat_q;
  logic           last_q;
  opnd_t          x_q;
  w_row_t         w_q;

  // Busy drops together with the completion pulse, so a start in that cycle is taken
  assign busy_o    = busy_q & ~z_valid_i;
  assign start_acc = start_i & ~busy_o;
  // Beats count only in ST_RUN, i.e. from the second cycle after the start
  assign beat_acc  = beat_valid_i & (state_q == ST_RUN);
  assign beat_last = (remain_q == K_W'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_acc) begin
          state_d = ST_BIAS;
        end
      end
      ST_BIAS: state_d = ST_RUN;
      ST_RUN: begin
        if (beat_acc && beat_last) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= ST_IDLE;
      busy_q   <= 1'b0;
      remain_q <= '0;
      beat_q   <= 1'b0;
      last_q   <= 1'b0;
      cmd_o    <= '0;
    end else begin
      state_q <= state_d;
      // Set wins over clear for back-to-back jobs
      if (start_acc) begin
        busy_q <= 1'b1;
      end else if (z_valid_i) begin
        busy_q <= 1'b0;
      end
      if (start_acc) begin
        remain_q <= k_len_i;
      end else if (beat_acc) begin
        remain_q <= remain_q - K_W'(1);
      end
      beat_q <= beat_acc;
      last_q <= beat_acc & beat_last;
      // Command stage, one cycle behind the sampled event
      if (state_q == ST_BIAS) begin
        cmd_o.op   <= OP_BIAS;
        cmd_o.last <= 1'b0;
      end else if (beat_q) begin
        cmd_o.op   <= OP_MAC;
        cmd_o.last <= last_q;
      end else begin
        cmd_o.op   <= OP_IDLE;
        cmd_o.last <= 1'b0;
      end
      cmd_o.x <= x_q;
      cmd_o.w <= w_q;
    end
  end

  // Operand capture
  always_ff @(posedge clk_i) begin
    if (start_acc) begin
      bias_o <= y_bias_i;
    end
    if (beat_acc) begin
      x_q <= x_i;
      w_q <= w_i;
    end
  end

endmodule : redmule_feeder

/* src/redmule_pe.sv */
/*
 * RedMulE processing element: registered signed multiply, then a wrapping
 * accumulator that loads the bias or adds the product
 */

`timescale 1ns/1ps

module redmule_pe (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  redmule_pkg::pe_cmd_t cmd_i,
  input  redmule_pkg::opnd_t   w_sel_i,
  input  redmule_pkg::acc_t    bias_i,
  output redmule_pkg::acc_t    acc_o,
  output logic                 last_o
);

  import redmule_pkg::*;

  acc_t   prod;
  acc_t   val_q;
  pe_op_e op_q;
  logic   last_q;

  // Operands sign-extended to the accumulator width first
  assign prod = acc_t'(cmd_i.x) * acc_t'(w_sel_i);

  // Stage 1: product or bias, with opcode and last flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q   <= OP_IDLE;
      last_q <= 1'b0;
    end else begin
      op_q   <= cmd_i.op;
      last_q <= cmd_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    val_q <= (cmd_i.op == OP_BIAS) ? bias_i : prod;
  end

  // Stage 2: accumulator, wraps modulo 2^ACC_W
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_o  <= '0;
      last_o <= 1'b0;
    end else begin
      last_o <= last_q;
      if (op_q == OP_BIAS) begin
        acc_o <= val_q;
      end else if (op_q == OP_MAC) begin
        acc_o <= acc_o + val_q;
      end
    end
  end

endmodule : redmule_pe

/* src/redmule_drain.sv */
/*
 * RedMulE drain: stores the PE accumulators once the last term has been
 * added and flags the finished result vector
 */

`timescale 1ns/1ps

module redmule_drain (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  redmule_pkg::acc_vec_t acc_i,
  input  logic                  last_i,
  output logic                  z_valid_o,
  output redmule_pkg::acc_vec_t z_o
);

  // last_i arrives with the final accumulator update
  // Capture one cycle later when every PE holds its final sum
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      z_valid_o <= 1'b0;
    end else begin
      z_valid_o <= last_i;
    end
  end

  // Result held until the next job completes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      z_o <= '0;
    end else if (last_i) begin
      z_o <= acc_i;
    end
  end

endmodule : redmule_drain

/* src/redmule_top.sv */
/*
 * RedMulE top: feeder, a row of multiply-accumulate PEs and the result drain,
 * computing z = y + x * W over K streamed beats
 */

`timescale 1ns/1ps

module redmule_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  logic [redmule_pkg::K_W-1:0] k_len_i,
  input  redmule_pkg::acc_vec_t       y_bias_i,
  input  logic                        beat_valid_i,
  input  redmule_pkg::opnd_t          x_i,
  input  redmule_pkg::w_row_t         w_i,
  output logic                        busy_o,
  output logic                        z_valid_o,
  output redmule_pkg::acc_vec_t       z_o
);

  import redmule_pkg::*;

  pe_cmd_t           cmd;
  acc_vec_t          bias;
  acc_vec_t          pe_acc;
  logic [NUM_PE-1:0] pe_last;

  redmule_feeder i_feeder (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .start_i      ( start_i      ),
    .k_len_i      ( k_len_i      ),
    .y_bias_i     ( y_bias_i     ),
    .beat_valid_i ( beat_valid_i ),
    .x_i          ( x_i          ),
    .w_i          ( w_i          ),
    .z_valid_i    ( z_valid_o    ),
    .busy_o       ( busy_o       ),
    .cmd_o        ( cmd          ),
    .bias_o       ( bias         )
  );

  // PE row, all in lockstep on the broadcast command
  for (genvar j = 0; j < NUM_PE; j++) begin : gen_pe
    redmule_pe i_pe (
      .clk_i   ( clk_i      ),
      .reset_i ( reset_i    ),
      .cmd_i   ( cmd        ),
      .w_sel_i ( cmd.w[j]   ),
      .bias_i  ( bias[j]    ),
      .acc_o   ( pe_acc[j]  ),
      .last_o  ( pe_last[j] )
    );
  end

  redmule_drain i_drain (
    .clk_i     ( clk_i      ),
    .reset_i   ( reset_i    ),
    .acc_i     ( pe_acc     ),
    .last_i    ( pe_last[0] ),
    .z_valid_o ( z_valid_o  ),
    .z_o       ( z_o        )
  );

endmodule : redmule_top

/* testbench/redmule_checker.sv */
/*
 * RedMulE result checker: follows the jobs at the DUT ports, checks result
 * timing and busy_o, and compares z_o with the expected vectors
 */

`timescale 1ns/1ps

module redmule_checker (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  logic [redmule_pkg::K_W-1:0] k_len_i,
  input  logic                        beat_valid_i,
  input  logic                        busy_i,
  input  logic                        z_valid_i,
  input  redmule_pkg::acc_vec_t       z_i,
  input  logic                        exp_push_i,
  input  redmule_pkg::acc_vec_t       exp_z_i,
  input  logic                        end_i,
  output int                          err_cnt_o,
  output int                          res_cnt_o
);

  import redmule_pkg::*;

  acc_vec_t exp_q[$];
  acc_vec_t exp_z;
  int       cyc;
  int       last_cyc;
  int       beats_left;
  logic     due_valid;
  logic     job_active;
  logic     first_cyc;

  task automatic value_error(input string sig, input logic [ACC_W-1:0] got,
                             input logic [ACC_W-1:0] exp);
    $display("Error: %s = %h, expected %h", sig, got, exp);
    err_cnt_o++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s (cycle %0d)", msg, cyc);
    err_cnt_o++;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      cyc        = 0;
      last_cyc   = 0;
      beats_left = 0;
      due_valid  = 1'b0;
      job_active = 1'b0;
      first_cyc  = 1'b1;
      err_cnt_o  = 0;
      res_cnt_o  = 0;
      exp_q.delete();
    end else begin
      cyc = cyc + 1;
      // Outputs still hold their reset values on the first edge
      if (first_cyc) begin
        first_cyc = 1'b0;
        if (busy_i !== 1'b0) begin
          value_error("busy_o", ACC_W'(busy_i), '0);
        end
        if (z_valid_i !== 1'b0) begin
          value_error("z_valid_o", ACC_W'(z_valid_i), '0);
        end
        for (int j = 0; j < NUM_PE; j++) begin
          if (z_i[j] !== '0) begin
            value_error($sformatf("z_o[%0d]", j), z_i[j], '0);
          end
        end
      end
      if (job_active && !z_valid_i && busy_i !== 1'b1) begin
        report_fault("busy_o dropped before z_valid_o");
      end
      if (!job_active && busy_i !== 1'b0) begin
        report_fault("busy_o is high with no job running");
      end
      if (z_valid_i === 1'b1) begin
        if (busy_i !== 1'b0) begin
          report_fault("busy_o still high while z_valid_o is set");
        end
        if (!due_valid) begin
          report_fault("z_valid_o pulsed with no finished job");
        end else if (cyc - last_cyc - 1 != 4) begin
          report_fault($sformatf("z_valid_o came %0d cycles after the last beat, not 4",
                                 cyc - last_cyc - 1));
        end
        due_valid  = 1'b0;
        job_active = 1'b0;
        if (exp_q.size() == 0) begin
          report_fault("z_valid_o pulsed with no expected vector left");
        end else begin
          exp_z = exp_q.pop_front();
          res_cnt_o++;
          for (int j = 0; j < NUM_PE; j++) begin
            if (z_i[j] !== exp_z[j]) begin
              value_error($sformatf("z_o[%0d]", j), z_i[j], exp_z[j]);
            end
          end
        end
      end else if (due_valid && cyc - last_cyc > 5) begin
        report_fault("z_valid_o missing after the last beat");
        due_valid = 1'b0;
      end
      if (beat_valid_i && beats_left > 0) begin
        beats_left--;
        if (beats_left == 0) begin
          due_valid = 1'b1;
          last_cyc  = cyc;
        end
      end
      // Accepted start only while busy_o is low
      if (start_i && !busy_i) begin
        job_active = 1'b1;
        beats_left = k_len_i;
      end
      if (exp_push_i) begin
        exp_q.push_back(exp_z_i);
      end
      if (end_i && exp_q.size() > 0) begin
        report_fault($sformatf("%0d expected results never arrived", exp_q.size()));
        exp_q.delete();
      end
    end
  end

endmodule : redmule_checker

/* testbench/redmule_sva.sv */
/*
 * Protocol assertions on the RedMulE completion handshake
 */

`timescale 1ns/1ps

module redmule_sva (
  input logic clk_i,
  input logic reset_i,
  input logic busy_i,
  input logic z_valid_i
);

  int err_cnt = 0;

  // Completion pulse lasts one cycle
  a_pulse_width: assert property (@(posedge clk_i) disable iff (reset_i)
    z_valid_i |=> !z_valid_i)
    else begin
      $error("z_valid_o stayed high for more than one cycle");
      err_cnt++;
    end

  // busy_o falls together with the rising pulse
  a_busy_fall: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(z_valid_i) |-> $fell(busy_i))
    else begin
      $error("busy_o did not fall when z_valid_o rose");
      err_cnt++;
    end

  a_valid_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    z_valid_i |-> $past(busy_i))
    else begin
      $error("z_valid_o set while busy_o was low in the cycle before");
      err_cnt++;
    end

endmodule : redmule_sva

bind redmule_top redmule_sva sva0 (
  .clk_i     ( clk_i     ),
  .reset_i   ( reset_i   ),
  .busy_i    ( busy_o    ),
  .z_valid_i ( z_valid_o )
);

/* testbench/tb_redmule.sv */
/*
 * RedMulE testbench: runs the jobs of the stimulus file through the DUT
 * with random gaps between beats and reports the outcome
 */

`timescale 1ns/1ps

module tb_redmule;

  import redmule_pkg::*;

  localparam int STIM_DEPTH   = 256;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_GAP      = 3;
  // Start, pipeline latency and idle cycles around one job
  localparam int JOB_CYCLES   = 12;
  localparam int MARGIN       = 50;

  logic           clk;
  logic           reset;
  logic           start;
  logic [K_W-1:0] k_len;
  acc_vec_t       y_bias;
  logic           beat_valid;
  opnd_t          x;
  w_row_t         w;
  logic           busy;
  logic           z_valid;
  acc_vec_t       z;
  logic           exp_push;
  acc_vec_t       exp_z;
  logic           chk_end;
  int             chk_errors;
  int             chk_results;

  logic [31:0] stim_mem [STIM_DEPTH];
  logic [31:0] lfsr = 32'h9155_a581;
  int          cycle_cnt = 0;
  int          timeout_cycles = 0;
  int          tb_errors = 0;
  int          num_jobs = 0;
  int          num_beats = 0;

  redmule_top dut0 (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .start_i      ( start      ),
    .k_len_i      ( k_len      ),
    .y_bias_i     ( y_bias     ),
    .beat_valid_i ( beat_valid ),
    .x_i          ( x          ),
    .w_i          ( w          ),
    .busy_o       ( busy       ),
    .z_valid_o    ( z_valid    ),
    .z_o          ( z          )
  );

  redmule_checker chk0 (
    .clk_i        ( clk         ),
    .reset_i      ( reset       ),
    .start_i      ( start       ),
    .k_len_i      ( k_len       ),
    .beat_valid_i ( beat_valid  ),
    .busy_i       ( busy        ),
    .z_valid_i    ( z_valid     ),
    .z_i          ( z           ),
    .exp_push_i   ( exp_push    ),
    .exp_z_i      ( exp_z       ),
    .end_i        ( chk_end     ),
    .err_cnt_o    ( chk_errors  ),
    .res_cnt_o    ( chk_results )
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // A zero or unread header word ends the job list
  function automatic logic stim_end(input int idx);
    return idx >= STIM_DEPTH || stim_mem[idx] === 32'h0 || $isunknown(stim_mem[idx]);
  endfunction

  task automatic count_jobs();
    int idx;
    idx = 0;
    while (!stim_end(idx)) begin
      num_jobs++;
      num_beats += stim_mem[idx][5:0];
      idx += 9 + 5 * stim_mem[idx][5:0];
    end
  endtask

  // Job words are the header, y0..y3, K beats of x w0..w3, then z0..z3
  task automatic run_job(input int idx);
    int k;
    int gap;
    int base;
    k        = stim_mem[idx][5:0];
    start    = 1'b1;
    k_len    = K_W'(k);
    exp_push = 1'b1;
    for (int j = 0; j < NUM_PE; j++) begin
      y_bias[j] = stim_mem[idx + 1 + j][ACC_W-1:0];
      exp_z[j]  = stim_mem[idx + 5 + 5 * k + j][ACC_W-1:0];
    end
    @(negedge clk);
    exp_push = 1'b0;
    // Second start while busy with other operands
    start    = (stim_mem[idx][11:8] == 4'd2);
    k_len    = K_W'(1);
    y_bias   = ~y_bias;
    @(negedge clk);
    start = 1'b0;
    // Feeder is in ST_RUN from the next edge on
    for (int b = 0; b < k; b++) begin
      base = idx + 5 + 5 * b;
      random_bits(2, gap);
      repeat (gap) @(negedge clk);
      beat_valid = 1'b1;
      x          = stim_mem[base][OPND_W-1:0];
      for (int j = 0; j < NUM_PE; j++) begin
        w[j] = stim_mem[base + 1 + j][OPND_W-1:0];
      end
      @(negedge clk);
      beat_valid = 1'b0;
    end
    do begin
      @(negedge clk);
    end while (z_valid !== 1'b1);
  endtask

  initial begin
    int idx;
    int sva_errors;
    reset      = 1'b1;
    start      = 1'b0;
    k_len      = '0;
    y_bias     = '0;
    beat_valid = 1'b0;
    x          = '0;
    w          = '0;
    exp_push   = 1'b0;
    exp_z      = '0;
    chk_end    = 1'b0;
    $readmemh("testbench/redmule_stim.txt", stim_mem);
    count_jobs();
    timeout_cycles = RESET_CYCLES + MARGIN + num_jobs * JOB_CYCLES
                     + num_beats * (MAX_GAP + 1);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    idx = 0;
    while (!stim_end(idx)) begin
      // Mode 1 starts in the cycle of the previous z_valid_o
      if (idx > 0 && stim_mem[idx][11:8] != 4'd1) begin
        repeat (2) @(negedge clk);
      end
      run_job(idx);
      idx += 9 + 5 * stim_mem[idx][5:0];
    end
    repeat (3) @(negedge clk);
    chk_end = 1'b1;
    @(negedge clk);
    chk_end = 1'b0;
    @(negedge clk);
    if (num_jobs == 0 || chk_results != num_jobs) begin
      $display("Checked %0d results for %0d jobs in the stimulus file", chk_results, num_jobs);
      tb_errors++;
    end
    sva_errors = dut0.sva0.err_cnt;
    $display("Jobs: %0d, results checked: %0d, errors: %0d, assertion failures: %0d",
             num_jobs, chk_results, chk_errors + tb_errors, sva_errors);
    if (chk_errors + tb_errors + sva_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_redmule

/* testbench/redmule_stim.txt */
// Job line: header {mode, K} then bias y0..y3; mode 0 starts after idle cycles,
// 1 starts on z_valid_o, 2 adds a start while busy. Then K lines x w0..w3, then z0..z3
// K=1 basic job
001 00000a 000014 00001e 000028
03 02 ff 05 00
000010 000011 00002d 000028
// K=3, negative operands, large bias wraps modulo 2^24
003 7ffff0 800005 000000 ffffff
80 80 7f 01 ff
7f 7f 80 fe 64
fb 0a f9 00 03
807ebf 7f8128 fffe82 00320c
// K=5 with mixed signs
005 000064 ffffce 000000 0003e8
01 01 02 03 04
fe 05 fa 07 f8
0a f6 00 14 01
9c 32 ce 01 ff
40 40 40 c0 02
fffc6f 002364 fff059 0004ea
// K=2 with a second start while busy
202 000005 000006 000007 000008
02 01 01 01 01
ff 03 fd 00 0a
000004 00000b 000009 000000
// Back-to-back jobs
101 ffffff 000000 000001 7fffff
ff ff 80 7f 01
000000 000080 ffff82 7ffffe
102 123456 000000 ffff00 400000
07 07 f9 10 00
f8 08 08 20 7f
123447 ffff8f fffe70 3ffc08
101 000001 000002 000003 000004
00 05 05 05 05
000001 000002 000003 000004
000

/* verilog.f */
src/redmule_pkg.sv
src/redmule_feeder.sv
src/redmule_pe.sv
src/redmule_drain.sv
src/redmule_top.sv
testbench/redmule_checker.sv
testbench/redmule_sva.sv
testbench/tb_redmule.sv

/* Bender.yml */
package:
  name: redmule_lite

sources:
  - src/redmule_pkg.sv
  - src/redmule_feeder.sv
  - src/redmule_pe.sv
  - src/redmule_drain.sv
  - src/redmule_top.sv
  - target: test
    files:
      - testbench/redmule_checker.sv
      - testbench/redmule_sva.sv
      - testbench/tb_redmule.sv
